//--- tlb_pkg.sv
package tlb_pkg;

   localparam int ADDR_W    = 32;
   localparam int PAGE_BITS = 12;                  // Page offset, not compared
   localparam int SET_W     = 2;
   localparam int OFF_W     = 2;
   localparam int IDX_W     = SET_W + 1 + OFF_W;   // Set, bank, offset
   localparam int VPN_W     = ADDR_W - PAGE_BITS;
   localparam int ENTRY_W   = 32;

   // Entry word fields
   localparam int E_VALID = 0;
   localparam int E_READ  = 1;
   localparam int E_WRITE = 2;
   localparam int E_COH   = 3;
   localparam int E_VPN   = 4;                     // VPN_W bits from here up

   typedef logic [ADDR_W-1:0]  vaddr_t;
   typedef logic [VPN_W-1:0]   vpn_t;
   typedef logic [IDX_W-1:0]   idx_t;
   typedef logic [OFF_W-1:0]   off_t;
   typedef logic [ENTRY_W-1:0] entry_t;

   typedef enum logic [1:0] {IDLE, RUN, DRAIN, REPORT} search_state_t;

   typedef struct packed {
      logic   valid;
      vaddr_t vaddr;
      logic   write;                               // 1 for a write access
   } tlb_req_t;

   typedef struct packed {
      logic   we;
      logic   sel;                                 // 0 entry RAM, 1 page RAM
      idx_t   idx;
      entry_t data;
   } tlb_cfg_t;

   typedef struct packed {
      logic              valid;
      logic              hit;
      logic              miss;
      logic              multi_hit;
      logic              prot;
      logic              coherent;
      logic [ADDR_W-1:0] paddr;
   } tlb_resp_t;

endpackage

//--- hdl/entry_ram.sv
`timescale 1ns/1ps

module entry_ram import tlb_pkg::*; #(
   parameter int DEPTH_W = IDX_W,
   parameter int WIDTH   = ENTRY_W
) (
   input  logic               clk_i,
   input  logic               we_i,
   input  logic [DEPTH_W-1:0] waddr_i,
   input  logic [DEPTH_W-1:0] raddr0_i,
   input  logic [DEPTH_W-1:0] raddr1_i,
   input  logic [WIDTH-1:0]   wdata_i,
   output logic [WIDTH-1:0]   rdata0_o,
   output logic [WIDTH-1:0]   rdata1_o
);

   logic [WIDTH-1:0] mem [2**DEPTH_W];

   // Shared write port
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Both read ports registered, one cycle of latency
   always_ff @(posedge clk_i) begin
      rdata0_o <= mem[raddr0_i];
      rdata1_o <= mem[raddr1_i];
   end

endmodule

//--- hdl/offset_counter.sv
`timescale 1ns/1ps

module offset_counter import tlb_pkg::*; (
   input  logic clk_i,
   input  logic rst_ni,
   input  logic start_i,
   input  logic stop_i,
   output off_t off_o,
   output off_t off_d_o,
   output logic busy_o,
   output logic last_o
);

   logic busy_q;
   off_t off_q;
   off_t off_d_q;

   // Offset 0 already sits on the counter when start arrives
   assign busy_o  = start_i || busy_q;
   assign off_o   = off_q;
   assign last_o  = busy_o && (off_q == '1);
   assign off_d_o = off_d_q;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         busy_q <= 1'b0;
         off_q  <= '0;
      end else if (busy_o) begin
         if (stop_i || last_o) begin
            busy_q <= 1'b0;
            off_q  <= '0;                          // Park at offset 0 for the next walk
         end else begin
            busy_q <= 1'b1;
            off_q  <= off_q + 1'b1;
         end
      end
   end

   // Lines up with the RAM read data
   always_ff @(posedge clk_i) begin
      off_d_q <= off_q;
   end

endmodule

//--- hdl/search_ctrl.sv
`timescale 1ns/1ps

module search_ctrl import tlb_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_ni,
   input  tlb_req_t req_i,
   input  logic     match_i,
   input  logic     busy_i,
   input  logic     last_i,
   output logic     start_o,
   output logic     stop_o,
   output logic     searching_o,
   output logic     send_outputs_o,
   output vaddr_t   vaddr_o,
   output logic     write_o
);

   search_state_t state_q;
   search_state_t state_d;
   vaddr_t        vaddr_q;
   logic          write_q;
   logic          searching_q;
   logic          walk_done_q;                     // Last offset has been issued

   // Requests outside IDLE are dropped
   assign start_o        = (state_q == IDLE) && req_i.valid;
   assign stop_o         = (state_q == RUN) && match_i;
   assign send_outputs_o = (state_q == REPORT);
   assign searching_o    = searching_q;
   assign write_o        = write_q;

   // Offset 0 is read in the accept cycle, before the address is latched
   assign vaddr_o = (state_q == IDLE) ? req_i.vaddr : vaddr_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (req_i.valid) begin
               state_d = RUN;
            end
         end
         RUN: begin
            if (match_i) begin
               state_d = DRAIN;
            end else if (walk_done_q && !searching_q) begin
               state_d = DRAIN;                    // Every offset checked, miss
            end
         end
         DRAIN: begin
            state_d = REPORT;                      // Read issued after a stop retires
         end
         REPORT: begin
            state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q     <= IDLE;
         searching_q <= 1'b0;
         walk_done_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         searching_q <= busy_i;                    // Data arrives one cycle after the read
         if (start_o) begin
            walk_done_q <= 1'b0;
         end else if (last_i) begin
            walk_done_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_o) begin
         vaddr_q <= req_i.vaddr;
         write_q <= req_i.write;
      end
   end

endmodule

//--- hdl/set_check.sv
`timescale 1ns/1ps

module set_check import tlb_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_ni,
   input  tlb_cfg_t cfg_i,
   input  vaddr_t   vaddr_i,
   input  logic     write_i,
   input  logic     searching_i,
   input  logic     send_outputs_i,
   input  off_t     off_i,
   input  off_t     off_d_i,
   output logic     match_o,
   output logic     hit_o,
   output logic     multi_hit_o,
   output logic     prot_o,
   output logic     coherent_o,
   output idx_t     hit_idx_o
);

   typedef enum logic {SEARCH, HIT} hit_state_t;

   hit_state_t       hit_q;
   hit_state_t       hit_d;
   logic [SET_W-1:0] set_sel;
   vpn_t             vpn;
   idx_t             raddr0;
   idx_t             raddr1;
   entry_t           rdata0;
   entry_t           rdata1;
   logic             port0_hit;
   logic             port1_hit;
   logic             sel_bank;
   entry_t           sel_entry;
   logic             sel_prot;
   idx_t             hit_idx_q;
   logic             multi_q;
   logic             prot_q;
   logic             coh_q;

   // Low page-number bits pick the set
   assign set_sel = vaddr_i[PAGE_BITS +: SET_W];
   assign vpn     = vaddr_i[ADDR_W-1:PAGE_BITS];
   assign raddr0  = {set_sel, 1'b0, off_i};
   assign raddr1  = {set_sel, 1'b1, off_i};

   entry_ram #(
      .DEPTH_W (IDX_W),
      .WIDTH   (ENTRY_W)
   ) u_entry_ram (
      .clk_i    (clk_i),
      .we_i     (cfg_i.we && !cfg_i.sel),
      .waddr_i  (cfg_i.idx),
      .raddr0_i (raddr0),
      .raddr1_i (raddr1),
      .wdata_i  (cfg_i.data),
      .rdata0_o (rdata0),
      .rdata1_o (rdata1)
   );

   assign port0_hit = rdata0[E_VALID] && (rdata0[E_VPN +: VPN_W] == vpn);
   assign port1_hit = rdata1[E_VALID] && (rdata1[E_VPN +: VPN_W] == vpn);

   assign sel_bank  = !port0_hit;                  // Bank 0 wins a tie
   assign sel_entry = port0_hit ? rdata0 : rdata1;
   assign sel_prot  = write_i ? !sel_entry[E_WRITE] : !sel_entry[E_READ];

   always_comb begin
      hit_d   = hit_q;
      match_o = 1'b0;
      case (hit_q)
         SEARCH: begin
            if (searching_i && (port0_hit || port1_hit)) begin
               match_o = 1'b1;
               hit_d   = HIT;
            end
         end
         HIT: begin
            // Later reads are ignored until the response goes out
            if (send_outputs_i) begin
               hit_d = SEARCH;
            end
         end
         default: begin
            hit_d = SEARCH;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         hit_q   <= SEARCH;
         multi_q <= 1'b0;
         prot_q  <= 1'b0;
         coh_q   <= 1'b0;
      end else begin
         hit_q <= hit_d;
         if (match_o) begin
            multi_q <= port0_hit && port1_hit;
            prot_q  <= sel_prot;
            coh_q   <= sel_entry[E_COH];
         end else if (send_outputs_i) begin
            multi_q <= 1'b0;
            prot_q  <= 1'b0;
            coh_q   <= 1'b0;
         end
      end
   end

   // Index of the matching entry, offset taken from the data side
   always_ff @(posedge clk_i) begin
      if (match_o) begin
         hit_idx_q <= {set_sel, sel_bank, off_d_i};
      end
   end

   assign hit_o       = (hit_q == HIT);
   assign multi_hit_o = multi_q;
   assign prot_o      = prot_q;
   assign coherent_o  = coh_q;
   assign hit_idx_o   = hit_idx_q;

endmodule

//--- hdl/pa_lookup.sv
`timescale 1ns/1ps

module pa_lookup import tlb_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_ni,
   input  tlb_cfg_t  cfg_i,
   input  idx_t      hit_idx_i,
   input  logic      hit_i,
   input  logic      multi_hit_i,
   input  logic      prot_i,
   input  logic      coherent_i,
   input  logic      send_outputs_i,
   input  vaddr_t    vaddr_i,
   output tlb_resp_t resp_o
);

   vpn_t pa_mem [2**IDX_W];                        // Physical page per entry
   vpn_t page_q;

   always_ff @(posedge clk_i) begin
      if (cfg_i.we && cfg_i.sel) begin
         pa_mem[cfg_i.idx] <= cfg_i.data[VPN_W-1:0];
      end
   end

   // Hit index is stable from DRAIN on, so the page is ready in REPORT
   always_ff @(posedge clk_i) begin
      page_q <= pa_mem[hit_idx_i];
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         resp_o <= '0;
      end else begin
         resp_o.valid <= send_outputs_i;           // One-cycle strobe
         if (send_outputs_i) begin
            resp_o.hit       <= hit_i;
            resp_o.miss      <= !hit_i;
            resp_o.multi_hit <= multi_hit_i;
            resp_o.prot      <= prot_i;
            resp_o.coherent  <= coherent_i;
            // Stored page joined with the request's page offset
            if (hit_i) begin
               resp_o.paddr <= {page_q, vaddr_i[PAGE_BITS-1:0]};
            end else begin
               resp_o.paddr <= '0;
            end
         end
      end
   end

endmodule

//--- hdl/tlb_slice_top.sv
`timescale 1ns/1ps

module tlb_slice_top import tlb_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_ni,
   input  tlb_req_t  req_i,
   input  tlb_cfg_t  cfg_i,
   output tlb_resp_t resp_o
);

   logic   start;
   logic   stop;
   logic   busy;
   logic   last;
   logic   searching;
   logic   send_outputs;
   logic   match;
   logic   hit;
   logic   multi_hit;
   logic   prot;
   logic   coherent;
   logic   write;
   vaddr_t vaddr;
   off_t   off;
   off_t   off_d;
   idx_t   hit_idx;

   search_ctrl u_search_ctrl (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .req_i          (req_i),
      .match_i        (match),
      .busy_i         (busy),
      .last_i         (last),
      .start_o        (start),
      .stop_o         (stop),
      .searching_o    (searching),
      .send_outputs_o (send_outputs),
      .vaddr_o        (vaddr),
      .write_o        (write)
   );

   offset_counter u_offset_counter (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .start_i (start),
      .stop_i  (stop),
      .off_o   (off),
      .off_d_o (off_d),
      .busy_o  (busy),
      .last_o  (last)
   );

   set_check u_set_check (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cfg_i          (cfg_i),
      .vaddr_i        (vaddr),
      .write_i        (write),
      .searching_i    (searching),
      .send_outputs_i (send_outputs),
      .off_i          (off),
      .off_d_i        (off_d),
      .match_o        (match),
      .hit_o          (hit),
      .multi_hit_o    (multi_hit),
      .prot_o         (prot),
      .coherent_o     (coherent),
      .hit_idx_o      (hit_idx)
   );

   pa_lookup u_pa_lookup (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cfg_i          (cfg_i),
      .hit_idx_i      (hit_idx),
      .hit_i          (hit),
      .multi_hit_i    (multi_hit),
      .prot_i         (prot),
      .coherent_i     (coherent),
      .send_outputs_i (send_outputs),
      .vaddr_i        (vaddr),
      .resp_o         (resp_o)
   );

endmodule

//--- verif/tlb_chk.sv
`timescale 1ns/1ps

module tlb_chk import tlb_pkg::*; (
   input logic      clk_i,
   input logic      rst_ni,
   input logic      start_i,
   input tlb_resp_t resp_i
);

   logic pending_q;                                // Accepted request awaiting its response

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pending_q <= 1'b0;
      end else if (start_i) begin
         pending_q <= 1'b1;
      end else if (resp_i.valid) begin
         pending_q <= 1'b0;
      end
   end

   resp_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_i.valid |=> !resp_i.valid)
      else $error("response valid held for more than one cycle");

   // A miss never carries hit or any of the hit-side flags
   miss_without_hit_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_i.miss |-> !resp_i.hit && !resp_i.multi_hit && !resp_i.prot && !resp_i.coherent)
      else $error("miss reported together with hit or hit flags");

   resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_i.valid |-> pending_q)
      else $error("response without an accepted request");

endmodule

bind tlb_slice_top tlb_chk u_tlb_chk (
   .clk_i   (clk_i),
   .rst_ni  (rst_ni),
   .start_i (start),
   .resp_i  (resp_o)
);

//--- verif/tlb_tb.sv
`timescale 1ns/1ps

module tlb_tb import tlb_pkg::*; ();

   typedef logic [31:0] word_t;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 4;
   localparam int SEED       = 32'h405;
   localparam int REQ_BOUND  = 2**OFF_W + 8;       // Cycles allowed per lookup
   localparam int NUM_REQ    = 18;
   localparam int NUM_CLEARS = 5;
   // Two cycles per table write, both RAMs cleared before each test
   localparam int CFG_CYCLES      = NUM_CLEARS * 4 * 2**IDX_W + 128;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + CFG_CYCLES + NUM_REQ * 2 * REQ_BOUND;

   logic      clk;
   logic      rst_n;
   tlb_req_t  req;
   tlb_cfg_t  cfg;
   tlb_resp_t resp;
   int        errors;

   entry_t model_entry [2**IDX_W];                 // Mirror of the entry RAM
   vpn_t   model_page  [2**IDX_W];

   tlb_slice_top UUT (
      .clk_i  (clk),
      .rst_ni (rst_n),
      .req_i  (req),
      .cfg_i  (cfg),
      .resp_o (resp)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   task automatic report_failure();
      $display("Test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare_value(input string name, input word_t got, input word_t want);
      if (got !== want) begin
         errors++;
         $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
         report_failure();
      end
   endtask

   function automatic entry_t make_entry(input vpn_t vpn, input logic valid, input logic rd,
                                         input logic wr, input logic coh);
      entry_t e;
      e                 = '0;
      e[E_VALID]        = valid;
      e[E_READ]         = rd;
      e[E_WRITE]        = wr;
      e[E_COH]          = coh;
      e[E_VPN +: VPN_W] = vpn;
      return e;
   endfunction

   function automatic idx_t entry_idx(input int set, input int bank, input int off);
      return {set[SET_W-1:0], bank[0], off[OFF_W-1:0]};
   endfunction

   // Random page number that falls into the given set
   function automatic vpn_t random_vpn(input int set);
      vpn_t v;
      v              = vpn_t'($urandom());
      v[SET_W-1:0]   = set[SET_W-1:0];
      return v;
   endfunction

   function automatic vaddr_t make_vaddr(input vpn_t vpn);
      vaddr_t v;
      v                        = vaddr_t'($urandom());   // Random page offset
      v[ADDR_W-1:PAGE_BITS]    = vpn;
      return v;
   endfunction

   task automatic cfg_write(input logic sel, input idx_t idx, input entry_t data);
      @(negedge clk);
      cfg.we   = 1'b1;
      cfg.sel  = sel;
      cfg.idx  = idx;
      cfg.data = data;
      if (sel) begin
         model_page[idx] = data[VPN_W-1:0];
      end else begin
         model_entry[idx] = data;
      end
      @(negedge clk);
      cfg.we = 1'b0;
   endtask

   task automatic place_entry(input idx_t idx, input vpn_t vpn, input logic rd,
                              input logic wr, input logic coh);
      cfg_write(1'b0, idx, make_entry(vpn, 1'b1, rd, wr, coh));
      cfg_write(1'b1, idx, entry_t'(vpn_t'($urandom())));
   endtask

   task automatic clear_all();
      for (int i = 0; i < 2**IDX_W; i++) begin
         cfg_write(1'b0, idx_t'(i), '0);
         cfg_write(1'b1, idx_t'(i), '0);
      end
   endtask

   // Lowest offset wins, bank 0 before bank 1 at the same offset
   task automatic predict(input vaddr_t va, input logic wr, output tlb_resp_t want,
                          output int lat);
      vpn_t             vpn;
      logic [SET_W-1:0] set_bits;
      entry_t           e0;
      entry_t           e1;
      logic             m0;
      logic             m1;
      idx_t             idx;
      bit               found;
      vpn       = va[ADDR_W-1:PAGE_BITS];
      set_bits  = vpn[SET_W-1:0];
      want      = '0;
      want.valid = 1'b1;
      want.miss  = 1'b1;
      lat       = 3 + 2**OFF_W;
      found     = 1'b0;
      for (int k = 0; k < 2**OFF_W && !found; k++) begin
         e0 = model_entry[{set_bits, 1'b0, off_t'(k)}];
         e1 = model_entry[{set_bits, 1'b1, off_t'(k)}];
         m0 = e0[E_VALID] && (e0[E_VPN +: VPN_W] == vpn);
         m1 = e1[E_VALID] && (e1[E_VPN +: VPN_W] == vpn);
         if (m0 || m1) begin
            found          = 1'b1;
            idx            = {set_bits, !m0, off_t'(k)};
            want.hit       = 1'b1;
            want.miss      = 1'b0;
            want.multi_hit = m0 && m1;
            want.prot      = wr ? !model_entry[idx][E_WRITE] : !model_entry[idx][E_READ];
            want.coherent  = model_entry[idx][E_COH];
            want.paddr     = {model_page[idx], va[PAGE_BITS-1:0]};
            lat            = 3 + k;
         end
      end
   endtask

   task automatic do_lookup(input vaddr_t va, input logic wr, input bit intrude,
                            input vaddr_t drop_va);
      tlb_resp_t want;
      int        lat;
      int        cycles;
      predict(va, wr, want, lat);
      @(negedge clk);
      req.valid = 1'b1;
      req.vaddr = va;
      req.write = wr;
      cycles    = 0;
      do begin
         @(negedge clk);
         cycles++;
         req.valid = 1'b0;
         if (intrude && cycles == 2) begin
            req.valid = 1'b1;                      // Arrives mid search
            req.vaddr = drop_va;
            req.write = !wr;
         end
         if (cycles > REQ_BOUND) begin
            $display("[ERROR] %0t no response within %0d cycles of a request", $time,
                     REQ_BOUND);
            report_failure();
         end
      end while (!resp.valid);
      compare_value("resp_o.hit", word_t'(resp.hit), word_t'(want.hit));
      compare_value("resp_o.miss", word_t'(resp.miss), word_t'(want.miss));
      compare_value("resp_o.multi_hit", word_t'(resp.multi_hit), word_t'(want.multi_hit));
      compare_value("resp_o.prot", word_t'(resp.prot), word_t'(want.prot));
      compare_value("resp_o.coherent", word_t'(resp.coherent), word_t'(want.coherent));
      compare_value("resp_o.paddr", word_t'(resp.paddr), word_t'(want.paddr));
      compare_value("latency", word_t'(cycles - 1), word_t'(lat));
      if (intrude) begin
         repeat (REQ_BOUND) begin
            @(negedge clk);
            compare_value("resp_o.valid", word_t'(resp.valid), '0);
         end
      end
   endtask

   task automatic test_hits();
      vpn_t vpn0;
      vpn_t vpn1;
      clear_all();
      for (int s = 0; s < 2**SET_W; s++) begin
         vpn0          = random_vpn(s);
         vpn1          = vpn0;
         vpn1[VPN_W-1] = !vpn0[VPN_W-1];
         place_entry(entry_idx(s, 0, int'($urandom_range(2**OFF_W-1))), vpn0, 1'b1, 1'b1,
                     1'($urandom()));
         place_entry(entry_idx(s, 1, int'($urandom_range(2**OFF_W-1))), vpn1, 1'b1, 1'b1,
                     1'($urandom()));
         do_lookup(make_vaddr(vpn0), 1'($urandom()), 1'b0, '0);
         do_lookup(make_vaddr(vpn1), 1'($urandom()), 1'b0, '0);
      end
   endtask

   task automatic test_misses();
      vpn_t vpn_a;
      vpn_t vpn_b;
      clear_all();
      vpn_a = random_vpn(1);
      vpn_b = random_vpn(1);
      place_entry(entry_idx(2, 0, 2), vpn_a, 1'b1, 1'b1, 1'b0);   // Tag of set 1 in set 2
      cfg_write(1'b0, entry_idx(1, 1, 3), make_entry(vpn_b, 1'b0, 1'b1, 1'b1, 1'b1));
      do_lookup(make_vaddr(vpn_a), 1'b0, 1'b0, '0);
      do_lookup(make_vaddr(vpn_b), 1'b0, 1'b0, '0);
      do_lookup(make_vaddr(random_vpn(3)), 1'b1, 1'b0, '0);     // Nothing in set 3
   endtask

   task automatic test_prot();
      vpn_t vpn_r;
      vpn_t vpn_w;
      clear_all();
      vpn_r          = random_vpn(0);
      vpn_w          = vpn_r;
      vpn_w[VPN_W-1] = !vpn_r[VPN_W-1];
      place_entry(entry_idx(0, 0, 1), vpn_r, 1'b1, 1'b0, 1'b0);   // Read only
      place_entry(entry_idx(0, 1, 2), vpn_w, 1'b0, 1'b1, 1'b1);   // Write only
      do_lookup(make_vaddr(vpn_r), 1'b1, 1'b0, '0);
      do_lookup(make_vaddr(vpn_r), 1'b0, 1'b0, '0);
      do_lookup(make_vaddr(vpn_w), 1'b0, 1'b0, '0);
      do_lookup(make_vaddr(vpn_w), 1'b1, 1'b0, '0);
   endtask

   task automatic test_multi();
      vpn_t vpn_m;
      vpn_t vpn_p;
      clear_all();
      vpn_m = random_vpn(2);
      vpn_p = random_vpn(3);
      place_entry(entry_idx(2, 0, 1), vpn_m, 1'b1, 1'b1, 1'b1);
      place_entry(entry_idx(2, 1, 1), vpn_m, 1'b1, 1'b1, 1'b0);
      do_lookup(make_vaddr(vpn_m), 1'b0, 1'b0, '0);
      // Bank 1 at offset 1 beats bank 0 at offset 3
      place_entry(entry_idx(3, 1, 1), vpn_p, 1'b1, 1'b1, 1'b0);
      place_entry(entry_idx(3, 0, 3), vpn_p, 1'b1, 1'b1, 1'b1);
      do_lookup(make_vaddr(vpn_p), 1'b0, 1'b0, '0);
   endtask

   task automatic test_drop();
      vpn_t vpn_d;
      vpn_t vpn_x;
      clear_all();
      vpn_d = random_vpn(1);
      vpn_x = random_vpn(2);
      place_entry(entry_idx(1, 0, 2), vpn_d, 1'b1, 1'b1, 1'b0);
      place_entry(entry_idx(2, 1, 0), vpn_x, 1'b1, 1'b1, 1'b1);   // Would hit if accepted
      do_lookup(make_vaddr(vpn_d), 1'b0, 1'b1, make_vaddr(vpn_x));
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("[ERROR] %0t watchdog expired before the tests finished", $time);
      report_failure();
   end

   initial begin
      void'($urandom(SEED));
      clk    = 1'b0;
      rst_n  = 1'b0;
      req    = '0;
      cfg    = '0;
      errors = 0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      test_hits();
      test_misses();
      test_prot();
      test_multi();
      test_drop();
      @(negedge clk);
      if (errors == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("[ERROR] %0t %0d checks failed", $time, errors);
         report_failure();
      end
   end

endmodule

//--- files.f
tlb_pkg.sv
hdl/entry_ram.sv
hdl/offset_counter.sv
hdl/search_ctrl.sv
hdl/set_check.sv
hdl/pa_lookup.sv
hdl/tlb_slice_top.sv
verif/tlb_chk.sv
verif/tlb_tb.sv

//--- Makefile
# Verilator build and run for the translation table slice

VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
